// File: branch_issue_top.f
+incdir+common
common/branch_pkg.sv
common/operand_bus_if.sv
hdl/phys_regfile.sv
hdl/regread_arbiter.sv
branch_station/branch_station.sv
hdl/branch_sched.sv
hdl/branch_eval.sv
hdl/branch_issue_top.sv
verification/branch_issue_tb.sv

// File: branch_station/branch_station.sv
/*
 * One branch reservation station. It holds a dispatched branch, gathers
 * both operands from register zero, the read port or a writeback
 * broadcast, and offers the entry to the scheduler when complete.
 */
`timescale 1ns/10ps

module branch_station (
	input logic clk,
	input logic rst,
	input logic load_i,
	input branch_pkg::branch_op_t op_i,
	input logic wb_valid_i,
	input branch_pkg::preg_t wb_preg_i,
	input branch_pkg::value_t wb_data_i,
	input logic free_i,
	operand_bus_if.station bus,
	output branch_pkg::station_state_t state_o,
	output branch_pkg::resolve_t entry_o
);

	branch_pkg::station_state_t state;
	branch_pkg::branch_op_t op_q;
	branch_pkg::value_t val_a;
	branch_pkg::value_t val_b;
	logic valid_a;
	logic valid_b;
	// A read was granted for the slot, so only a broadcast can fill it now
	logic tried_a;
	logic tried_b;
	logic inflight;

	logic ld_zero_a;
	logic ld_zero_b;
	logic ld_va;
	logic ld_vb;
	logic need_a;
	logic need_b;
	logic wb_a;
	logic wb_b;
	logic rsp_a;
	logic rsp_b;
	logic next_a;
	logic next_b;

	// ============================================================
	// Operand capture
	// ============================================================

	// At load a zero source or a same-cycle writeback is valid at once
	assign ld_zero_a = op_i.psrc_a == '0;
	assign ld_zero_b = op_i.psrc_b == '0;
	assign ld_va = ld_zero_a || (wb_valid_i && wb_preg_i == op_i.psrc_a);
	assign ld_vb = ld_zero_b || (wb_valid_i && wb_preg_i == op_i.psrc_b);

	assign wb_a = state == branch_pkg::ST_WAIT && !valid_a && wb_valid_i
		&& wb_preg_i == op_q.psrc_a;
	assign wb_b = state == branch_pkg::ST_WAIT && !valid_b && wb_valid_i
		&& wb_preg_i == op_q.psrc_b;
	assign rsp_a = state == branch_pkg::ST_WAIT && !valid_a && bus.rsp_valid
		&& bus.rsp_ready && !bus.rsp_slot;
	assign rsp_b = state == branch_pkg::ST_WAIT && !valid_b && bus.rsp_valid
		&& bus.rsp_ready && bus.rsp_slot;
	assign next_a = valid_a || wb_a || rsp_a;
	assign next_b = valid_b || wb_b || rsp_b;

	// Read requests go out one operand at a time, A first
	assign need_a = !valid_a && !tried_a;
	assign need_b = !valid_b && !tried_b;
	assign bus.req = state == branch_pkg::ST_WAIT && !inflight && (need_a || need_b);
	assign bus.req_slot = !need_a;
	assign bus.req_preg = need_a ? op_q.psrc_a : op_q.psrc_b;

	// ============================================================
	// Control state
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= branch_pkg::ST_IDLE;
			valid_a <= 1'b0;
			valid_b <= 1'b0;
			tried_a <= 1'b0;
			tried_b <= 1'b0;
			inflight <= 1'b0;
		end else begin
			// A late response after the slot filled is simply dropped
			if (bus.rsp_valid)
				inflight <= 1'b0;
			case (state)
				branch_pkg::ST_IDLE: begin
					if (load_i) begin
						valid_a <= ld_va;
						valid_b <= ld_vb;
						tried_a <= 1'b0;
						tried_b <= 1'b0;
						state <= (ld_va && ld_vb) ? branch_pkg::ST_READY
							: branch_pkg::ST_WAIT;
					end
				end
				branch_pkg::ST_WAIT: begin
					valid_a <= next_a;
					valid_b <= next_b;
					if (bus.gnt) begin
						inflight <= 1'b1;
						tried_a <= tried_a | !bus.req_slot;
						tried_b <= tried_b | bus.req_slot;
					end
					if (next_a && next_b)
						state <= branch_pkg::ST_READY;
				end
				default: begin
					if (free_i)
						state <= branch_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// Payload, written on load and on each capture
	always_ff @(posedge clk) begin
		if (load_i) begin
			op_q <= op_i;
			val_a <= ld_zero_a ? '0 : wb_data_i;
			val_b <= ld_zero_b ? '0 : wb_data_i;
		end else begin
			if (wb_a)
				val_a <= wb_data_i;
			else if (rsp_a)
				val_a <= bus.rsp_data;
			if (wb_b)
				val_b <= wb_data_i;
			else if (rsp_b)
				val_b <= bus.rsp_data;
		end
	end

	assign state_o = state;
	assign entry_o.robid = op_q.robid;
	assign entry_o.brclass = op_q.brclass;
	assign entry_o.pc = op_q.pc;
	assign entry_o.imm = op_q.imm;
	assign entry_o.opa = val_a;
	assign entry_o.opb = val_b;
	assign entry_o.pdst = op_q.pdst;

	// The scheduler only steers dispatch into an empty station
	a_load_when_idle: assert property (@(posedge clk) disable iff (rst)
		load_i |-> state == branch_pkg::ST_IDLE);

endmodule

// File: common/branch_defs.svh
/*
 * Width and count macros for the branch issue slice.
 * Include this file wherever a width or count is needed.
 */
`ifndef BRANCH_DEFS_SVH
`define BRANCH_DEFS_SVH

// Data and address width
`define BR_XLEN 32

// Physical register file size and register number width
`define BR_NPREG 64
`define BR_PREG_W 6

// Number of peer branch stations
`define BR_NSTATION 2

// Reorder buffer tag width
`define BR_ROBID_W 5

`endif

// File: common/branch_pkg.sv
/*
 * Shared types for the branch issue slice.
 * Users refer to them by scoped name, for example branch_pkg::preg_t.
 */
`include "branch_defs.svh"

package branch_pkg;

	// Physical register number; register 0 always reads as zero
	typedef logic [`BR_PREG_W-1:0] preg_t;

	typedef logic [`BR_XLEN-1:0] value_t;

	typedef logic [`BR_ROBID_W-1:0] robid_t;

	// Branch opcodes, conditional compares first and then the two jumps
	typedef enum logic [2:0] {
		BRC_EQ,
		BRC_NE,
		BRC_LT,
		BRC_GE,
		BRC_LTU,
		BRC_GEU,
		BRC_JAL,
		BRC_JALR
	} brclass_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_READY
	} station_state_t;

	// Renamed operation as it leaves dispatch
	typedef struct packed {
		robid_t robid;
		brclass_t brclass;
		value_t pc;
		value_t imm;
		preg_t psrc_a;
		preg_t psrc_b;
		preg_t pdst;
	} branch_op_t;

	// Fully gathered operation as the evaluator takes it
	typedef struct packed {
		robid_t robid;
		brclass_t brclass;
		value_t pc;
		value_t imm;
		value_t opa;
		value_t opb;
		preg_t pdst;
	} resolve_t;

endpackage

// File: common/operand_bus_if.sv
/*
 * Read request and response between one branch station and the
 * register read arbiter. One instance is made per station.
 */
`timescale 1ns/10ps

interface operand_bus_if;

	// Request side, held by the station until gnt is seen
	logic req;
	branch_pkg::preg_t req_preg;
	// Operand selector, 0 for A and 1 for B
	logic req_slot;

	// Grant pulse and the response one cycle later
	logic gnt;
	logic rsp_valid;
	logic rsp_ready;
	logic rsp_slot;
	branch_pkg::value_t rsp_data;

	modport station (
		output req, req_preg, req_slot,
		input gnt, rsp_valid, rsp_ready, rsp_slot, rsp_data
	);

	modport arbiter (
		input req, req_preg, req_slot,
		output gnt, rsp_valid, rsp_ready, rsp_slot, rsp_data
	);

endinterface

// File: hdl/branch_eval.sv
/*
 * Branch evaluator. Computes taken, target and link for the issued
 * entry and registers them, so resolve_valid_o follows issue by one cycle.
 */
`timescale 1ns/10ps

module branch_eval (
	input logic clk,
	input logic rst,
	input logic issue_i,
	input branch_pkg::resolve_t entry_i,
	output logic resolve_valid_o,
	output branch_pkg::robid_t resolve_robid_o,
	output logic resolve_taken_o,
	output branch_pkg::value_t resolve_target_o,
	output branch_pkg::value_t resolve_link_o,
	output branch_pkg::preg_t resolve_pdst_o
);

	logic taken;
	logic is_jump;
	branch_pkg::value_t jalr_sum;
	branch_pkg::value_t target;
	branch_pkg::value_t link;

	always_comb begin
		case (entry_i.brclass)
			branch_pkg::BRC_EQ: taken = entry_i.opa == entry_i.opb;
			branch_pkg::BRC_NE: taken = entry_i.opa != entry_i.opb;
			branch_pkg::BRC_LT: taken = $signed(entry_i.opa) < $signed(entry_i.opb);
			branch_pkg::BRC_GE: taken = $signed(entry_i.opa) >= $signed(entry_i.opb);
			branch_pkg::BRC_LTU: taken = entry_i.opa < entry_i.opb;
			branch_pkg::BRC_GEU: taken = entry_i.opa >= entry_i.opb;
			default: taken = 1'b1;
		endcase
	end

	assign is_jump = entry_i.brclass == branch_pkg::BRC_JAL
		|| entry_i.brclass == branch_pkg::BRC_JALR;

	// JALR is register relative with bit 0 cleared, all others pc relative
	assign jalr_sum = entry_i.opa + entry_i.imm;
	assign target = (entry_i.brclass == branch_pkg::BRC_JALR)
		? {jalr_sum[$bits(jalr_sum)-1:1], 1'b0} : entry_i.pc + entry_i.imm;
	assign link = is_jump ? entry_i.pc + 4 : '0;

	always_ff @(posedge clk) begin
		if (rst)
			resolve_valid_o <= 1'b0;
		else
			resolve_valid_o <= issue_i;
	end

	// Result fields only change on issue
	always_ff @(posedge clk) begin
		if (issue_i) begin
			resolve_robid_o <= entry_i.robid;
			resolve_taken_o <= taken;
			resolve_target_o <= target;
			resolve_link_o <= link;
			resolve_pdst_o <= entry_i.pdst;
		end
	end

endmodule

// File: hdl/branch_issue_top.sv
/*
 * Top level of the branch resolution slice. Packs the dispatch ports
 * and connects register file, arbiter, stations, scheduler and evaluator.
 */
`timescale 1ns/10ps
`include "branch_defs.svh"

module branch_issue_top (
	input logic clk,
	input logic rst,
	input logic dispatch_valid_i,
	input branch_pkg::robid_t dispatch_robid_i,
	input branch_pkg::brclass_t dispatch_class_i,
	input branch_pkg::value_t dispatch_pc_i,
	input branch_pkg::value_t dispatch_imm_i,
	input branch_pkg::preg_t dispatch_psrc_a_i,
	input branch_pkg::preg_t dispatch_psrc_b_i,
	input branch_pkg::preg_t dispatch_pdst_i,
	output logic dispatch_ready_o,
	input logic wb_valid_i,
	input branch_pkg::preg_t wb_preg_i,
	input branch_pkg::value_t wb_data_i,
	input logic alloc_valid_i,
	input branch_pkg::preg_t alloc_preg_i,
	output logic resolve_valid_o,
	output branch_pkg::robid_t resolve_robid_o,
	output logic resolve_taken_o,
	output branch_pkg::value_t resolve_target_o,
	output branch_pkg::value_t resolve_link_o,
	output branch_pkg::preg_t resolve_pdst_o
);

	branch_pkg::branch_op_t dispatch_op;
	branch_pkg::station_state_t st_state [`BR_NSTATION];
	branch_pkg::resolve_t st_entry [`BR_NSTATION];
	branch_pkg::resolve_t issue_entry;
	logic [`BR_NSTATION-1:0] st_load;
	logic [`BR_NSTATION-1:0] st_free;
	logic issue;
	logic rd_en;
	branch_pkg::preg_t rd_preg;
	branch_pkg::value_t rd_data;
	logic rd_ready;

	operand_bus_if bus0 ();
	operand_bus_if bus1 ();

	assign dispatch_op.robid = dispatch_robid_i;
	assign dispatch_op.brclass = dispatch_class_i;
	assign dispatch_op.pc = dispatch_pc_i;
	assign dispatch_op.imm = dispatch_imm_i;
	assign dispatch_op.psrc_a = dispatch_psrc_a_i;
	assign dispatch_op.psrc_b = dispatch_psrc_b_i;
	assign dispatch_op.pdst = dispatch_pdst_i;

	// ============================================================
	// Register file and its shared read port
	// ============================================================

	phys_regfile u_regfile (
		.clk(clk),
		.rst(rst),
		.wr_en_i(wb_valid_i),
		.wr_preg_i(wb_preg_i),
		.wr_data_i(wb_data_i),
		.alloc_en_i(alloc_valid_i),
		.alloc_preg_i(alloc_preg_i),
		.rd_en_i(rd_en),
		.rd_preg_i(rd_preg),
		.rd_data_o(rd_data),
		.rd_ready_o(rd_ready)
	);

	regread_arbiter u_arbiter (
		.clk(clk),
		.rst(rst),
		.s0_bus(bus0.arbiter),
		.s1_bus(bus1.arbiter),
		.rd_en_o(rd_en),
		.rd_preg_o(rd_preg),
		.rd_data_i(rd_data),
		.rd_ready_i(rd_ready)
	);

	// ============================================================
	// Stations, scheduler and evaluator
	// ============================================================

	branch_station u_station0 (
		.clk(clk),
		.rst(rst),
		.load_i(st_load[0]),
		.op_i(dispatch_op),
		.wb_valid_i(wb_valid_i),
		.wb_preg_i(wb_preg_i),
		.wb_data_i(wb_data_i),
		.free_i(st_free[0]),
		.bus(bus0.station),
		.state_o(st_state[0]),
		.entry_o(st_entry[0])
	);

	branch_station u_station1 (
		.clk(clk),
		.rst(rst),
		.load_i(st_load[1]),
		.op_i(dispatch_op),
		.wb_valid_i(wb_valid_i),
		.wb_preg_i(wb_preg_i),
		.wb_data_i(wb_data_i),
		.free_i(st_free[1]),
		.bus(bus1.station),
		.state_o(st_state[1]),
		.entry_o(st_entry[1])
	);

	branch_sched u_sched (
		.clk(clk),
		.rst(rst),
		.dispatch_valid_i(dispatch_valid_i),
		.state_i(st_state),
		.entry_i(st_entry),
		.load_o(st_load),
		.free_o(st_free),
		.dispatch_ready_o(dispatch_ready_o),
		.issue_o(issue),
		.issue_entry_o(issue_entry)
	);

	branch_eval u_eval (
		.clk(clk),
		.rst(rst),
		.issue_i(issue),
		.entry_i(issue_entry),
		.resolve_valid_o(resolve_valid_o),
		.resolve_robid_o(resolve_robid_o),
		.resolve_taken_o(resolve_taken_o),
		.resolve_target_o(resolve_target_o),
		.resolve_link_o(resolve_link_o),
		.resolve_pdst_o(resolve_pdst_o)
	);

endmodule

// File: hdl/branch_sched.sv
/*
 * Branch scheduler. Steers dispatch into the lowest idle station and
 * sends the lowest ready station to the evaluator, freeing it.
 */
`timescale 1ns/10ps
`include "branch_defs.svh"

module branch_sched (
	input logic clk,
	input logic rst,
	input logic dispatch_valid_i,
	input branch_pkg::station_state_t state_i [`BR_NSTATION],
	input branch_pkg::resolve_t entry_i [`BR_NSTATION],
	output logic [`BR_NSTATION-1:0] load_o,
	output logic [`BR_NSTATION-1:0] free_o,
	output logic dispatch_ready_o,
	output logic issue_o,
	output branch_pkg::resolve_t issue_entry_o
);

	// Fixed priority by station number for both choices
	always_comb begin
		load_o = '0;
		free_o = '0;
		dispatch_ready_o = 1'b0;
		issue_o = 1'b0;
		issue_entry_o = entry_i[0];
		for (int s = 0; s < `BR_NSTATION; s++) begin
			if (state_i[s] == branch_pkg::ST_IDLE && !dispatch_ready_o) begin
				dispatch_ready_o = 1'b1;
				load_o[s] = dispatch_valid_i;
			end
			if (state_i[s] == branch_pkg::ST_READY && !issue_o) begin
				issue_o = 1'b1;
				free_o[s] = 1'b1;
				issue_entry_o = entry_i[s];
			end
		end
	end

	// Dispatch must wait for a free station
	a_dispatch_ready: assert property (@(posedge clk) disable iff (rst)
		dispatch_valid_i |-> dispatch_ready_o);

endmodule

// File: hdl/phys_regfile.sv
/*
 * Physical register file with one ready bit per register.
 * One write port sets ready, allocation clears it, and the single
 * read port returns data and ready one cycle after the request.
 */
`timescale 1ns/10ps
`include "branch_defs.svh"

module phys_regfile (
	input logic clk,
	input logic rst,
	input logic wr_en_i,
	input branch_pkg::preg_t wr_preg_i,
	input branch_pkg::value_t wr_data_i,
	input logic alloc_en_i,
	input branch_pkg::preg_t alloc_preg_i,
	input logic rd_en_i,
	input branch_pkg::preg_t rd_preg_i,
	output branch_pkg::value_t rd_data_o,
	output logic rd_ready_o
);

	branch_pkg::value_t regs [`BR_NPREG];
	logic [`BR_NPREG-1:0] ready;

	// Register 0 is never written and never loses its ready bit
	always_ff @(posedge clk) begin
		if (rst) begin
			ready <= '1;
			for (int i = 0; i < `BR_NPREG; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (alloc_en_i && alloc_preg_i != '0)
				ready[alloc_preg_i] <= 1'b0;
			if (wr_en_i && wr_preg_i != '0) begin
				regs[wr_preg_i] <= wr_data_i;
				ready[wr_preg_i] <= 1'b1;
			end
		end
	end

	// Registered read, a write in the same cycle is forwarded
	always_ff @(posedge clk) begin
		if (rd_en_i) begin
			if (rd_preg_i == '0) begin
				rd_data_o <= '0;
				rd_ready_o <= 1'b1;
			end else if (wr_en_i && wr_preg_i == rd_preg_i) begin
				rd_data_o <= wr_data_i;
				rd_ready_o <= 1'b1;
			end else begin
				rd_data_o <= regs[rd_preg_i];
				rd_ready_o <= ready[rd_preg_i];
			end
		end
	end

	// Rename never reallocates a register while its producer writes back
	a_no_wr_alloc_clash: assert property (@(posedge clk) disable iff (rst)
		!(wr_en_i && alloc_en_i && wr_preg_i == alloc_preg_i));

endmodule

// File: hdl/regread_arbiter.sv
/*
 * Round-robin arbiter for the single register read port.
 * Grants one station per cycle and steers the registered response back
 * to that station one cycle later.
 */
`timescale 1ns/10ps

module regread_arbiter (
	input logic clk,
	input logic rst,
	operand_bus_if.arbiter s0_bus,
	operand_bus_if.arbiter s1_bus,
	output logic rd_en_o,
	output branch_pkg::preg_t rd_preg_o,
	input branch_pkg::value_t rd_data_i,
	input logic rd_ready_i
);

	// Station that wins when both request, flips after every grant
	logic prio;
	logic gnt0;
	logic gnt1;
	logic gnt_slot;
	// Response tracking for the read that is in flight
	logic pend_q;
	logic pend_stn_q;
	logic pend_slot_q;

	assign gnt0 = s0_bus.req && (!s1_bus.req || !prio);
	assign gnt1 = s1_bus.req && (!s0_bus.req || prio);
	assign s0_bus.gnt = gnt0;
	assign s1_bus.gnt = gnt1;

	assign rd_en_o = gnt0 | gnt1;
	assign rd_preg_o = gnt1 ? s1_bus.req_preg : s0_bus.req_preg;
	assign gnt_slot = gnt1 ? s1_bus.req_slot : s0_bus.req_slot;

	always_ff @(posedge clk) begin
		if (rst) begin
			prio <= 1'b0;
			pend_q <= 1'b0;
		end else begin
			pend_q <= rd_en_o;
			if (rd_en_o) begin
				prio <= gnt0;
				pend_stn_q <= gnt1;
				pend_slot_q <= gnt_slot;
			end
		end
	end

	// The response fields are shared, only rsp_valid is steered
	assign s0_bus.rsp_valid = pend_q && !pend_stn_q;
	assign s1_bus.rsp_valid = pend_q && pend_stn_q;
	assign s0_bus.rsp_ready = rd_ready_i;
	assign s1_bus.rsp_ready = rd_ready_i;
	assign s0_bus.rsp_slot = pend_slot_q;
	assign s1_bus.rsp_slot = pend_slot_q;
	assign s0_bus.rsp_data = rd_data_i;
	assign s1_bus.rsp_data = rd_data_i;

	// A station passed over wins the port the next cycle it still asks
	a_rr_turn0: assert property (@(posedge clk) disable iff (rst)
		s0_bus.req && gnt1 |=> !s0_bus.req || gnt0);
	a_rr_turn1: assert property (@(posedge clk) disable iff (rst)
		s1_bus.req && gnt0 |=> !s1_bus.req || gnt1);

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the branch issue slice with its testbench and run it with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f branch_issue_top.f --top-module branch_issue_tb

out=$(./obj_dir/Vbranch_issue_tb)
echo "$out"

if echo "$out" | grep -q "^TESTBENCH PASSED$"; then
	exit 0
fi
exit 1

// File: verification/branch_issue_tb.sv
/*
 * Table-driven testbench for the branch issue slice. Each row presets
 * registers, dispatches one branch and checks the resolved result.
 * Results are matched to rows by rob id, so they may return in any order.
 */
`timescale 1ns/10ps
`include "branch_defs.svh"

module branch_issue_tb;

	localparam int NROWS = 24;
	localparam int NDIRECTED = 12;
	localparam int TIMEOUT = 200;

	// One stimulus row with its expected result
	typedef struct packed {
		branch_pkg::brclass_t cls;
		branch_pkg::value_t pc;
		branch_pkg::value_t imm;
		branch_pkg::preg_t src_a;
		branch_pkg::value_t val_a;
		branch_pkg::preg_t src_b;
		branch_pkg::value_t val_b;
		logic late_b;
		logic hold;
		logic exp_taken;
		branch_pkg::value_t exp_target;
		branch_pkg::value_t exp_link;
	} row_t;

	logic clk;
	logic rst;
	logic dispatch_valid_i;
	branch_pkg::robid_t dispatch_robid_i;
	branch_pkg::brclass_t dispatch_class_i;
	branch_pkg::value_t dispatch_pc_i;
	branch_pkg::value_t dispatch_imm_i;
	branch_pkg::preg_t dispatch_psrc_a_i;
	branch_pkg::preg_t dispatch_psrc_b_i;
	branch_pkg::preg_t dispatch_pdst_i;
	logic dispatch_ready_o;
	logic wb_valid_i;
	branch_pkg::preg_t wb_preg_i;
	branch_pkg::value_t wb_data_i;
	logic alloc_valid_i;
	branch_pkg::preg_t alloc_preg_i;
	logic resolve_valid_o;
	branch_pkg::robid_t resolve_robid_o;
	logic resolve_taken_o;
	branch_pkg::value_t resolve_target_o;
	branch_pkg::value_t resolve_link_o;
	branch_pkg::preg_t resolve_pdst_o;

	row_t rows [NROWS];
	int pending [$];
	int late_rows [$];
	logic [31:0] rng_state;
	int cycle = 0;
	int cur_row;
	int error_count;
	int stray_results;
	int rows_ok;
	int rows_bad;
	bit timed_out;

	// Results as seen on the resolve port, indexed by rob id
	bit issued [32];
	bit got_valid [32];
	bit got_taken [32];
	branch_pkg::value_t got_target [32];
	branch_pkg::value_t got_link [32];
	branch_pkg::preg_t got_pdst [32];
	int got_cycle [32];
	int late_cycle [32];

	branch_issue_top DUT (.*);

	always #5 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	// Outputs are registered, so the falling edge sees them settled
	always @(negedge clk) begin
		if (!rst && resolve_valid_o) begin
			if (!issued[resolve_robid_o] || got_valid[resolve_robid_o]) begin
				stray_results++;
				$display("error at %0t ns: unexpected result for rob id %0d",
					$time, resolve_robid_o);
			end else begin
				got_valid[resolve_robid_o] = 1'b1;
				got_taken[resolve_robid_o] = resolve_taken_o;
				got_target[resolve_robid_o] = resolve_target_o;
				got_link[resolve_robid_o] = resolve_link_o;
				got_pdst[resolve_robid_o] = resolve_pdst_o;
				got_cycle[resolve_robid_o] = cycle;
			end
		end
	end

	// ============================================================
	// Helpers
	// ============================================================

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Conditional compare as the branch classes define it
	function automatic logic ordered_taken(input branch_pkg::brclass_t cls,
		input logic [31:0] a, input logic [31:0] b);
		case (cls)
			branch_pkg::BRC_LT: return $signed(a) < $signed(b);
			branch_pkg::BRC_GE: return $signed(a) >= $signed(b);
			branch_pkg::BRC_LTU: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("error at %0t ns: row %0d %s, got %h expected %h",
				$time, cur_row, what, got, exp);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic report_timeout(input string what, input int r);
		if (!timed_out)
			$display("timeout: %s for row %0d at %0t ns", what, r, $time);
		timed_out = 1'b1;
	endtask

	task automatic write_reg(input branch_pkg::preg_t p, input branch_pkg::value_t v);
		wb_valid_i = 1'b1;
		wb_preg_i = p;
		wb_data_i = v;
		next_cycle();
		wb_valid_i = 1'b0;
	endtask

	// Allocation clears the ready bit, as rename would for a new producer
	task automatic alloc_reg(input branch_pkg::preg_t p);
		alloc_valid_i = 1'b1;
		alloc_preg_i = p;
		next_cycle();
		alloc_valid_i = 1'b0;
	endtask

	task automatic set_row(input int idx, input branch_pkg::brclass_t cls,
		input logic [31:0] pc, input logic [31:0] imm,
		input branch_pkg::preg_t sa, input logic [31:0] va,
		input branch_pkg::preg_t sb, input logic [31:0] vb,
		input logic late, input logic hold, input logic taken,
		input logic [31:0] target, input logic [31:0] link);
		rows[idx].cls = cls;
		rows[idx].pc = pc;
		rows[idx].imm = imm;
		rows[idx].src_a = sa;
		rows[idx].val_a = va;
		rows[idx].src_b = sb;
		rows[idx].val_b = vb;
		rows[idx].late_b = late;
		rows[idx].hold = hold;
		rows[idx].exp_taken = taken;
		rows[idx].exp_target = target;
		rows[idx].exp_link = link;
	endtask

	// ============================================================
	// Stimulus table
	// ============================================================

	task automatic build_table();
		branch_pkg::brclass_t cls;
		logic [31:0] va;
		logic [31:0] vb;
		logic [31:0] pc;
		logic [31:0] imm;
		// Every conditional class with both operands read through the port
		set_row(0, branch_pkg::BRC_EQ, 32'h1000, 32'h40, 6'd1, 32'h1234,
			6'd2, 32'h1234, 0, 0, 1, 32'h1040, 0);
		set_row(1, branch_pkg::BRC_NE, 32'h2000, 32'h10, 6'd1, 32'h5,
			6'd2, 32'h5, 0, 0, 0, 32'h2010, 0);
		set_row(2, branch_pkg::BRC_LT, 32'h100, 32'hFFFF_FFF0, 6'd1, 32'hFFFF_FFFD,
			6'd2, 32'h2, 0, 0, 1, 32'hF0, 0);
		set_row(3, branch_pkg::BRC_GE, 32'h3000, 32'h8, 6'd1, 32'hFFFF_FFFD,
			6'd2, 32'h2, 0, 0, 0, 32'h3008, 0);
		set_row(4, branch_pkg::BRC_LTU, 32'h4000, 32'h100, 6'd1, 32'hFFFF_FFFD,
			6'd2, 32'h2, 0, 0, 0, 32'h4100, 0);
		set_row(5, branch_pkg::BRC_GEU, 32'h5000, 32'h4, 6'd1, 32'hFFFF_FFFD,
			6'd2, 32'h2, 0, 0, 1, 32'h5004, 0);
		// Register zero against a nonzero value
		set_row(6, branch_pkg::BRC_EQ, 32'h6000, 32'h20, 6'd0, 32'h0,
			6'd3, 32'h7, 0, 0, 0, 32'h6020, 0);
		// Operand B allocated and written only after dispatch
		set_row(7, branch_pkg::BRC_EQ, 32'h7000, 32'h80, 6'd4, 32'h55,
			6'd5, 32'h55, 1, 0, 1, 32'h7080, 0);
		set_row(8, branch_pkg::BRC_JAL, 32'h8000, 32'h400, 6'd0, 32'h0,
			6'd0, 32'h0, 0, 0, 1, 32'h8400, 32'h8004);
		set_row(9, branch_pkg::BRC_JALR, 32'h9000, 32'h10, 6'd6, 32'h9001,
			6'd0, 32'h0, 0, 0, 1, 32'h9010, 32'h9004);
		// Back to back, both waiting, so both stations are busy together
		set_row(10, branch_pkg::BRC_NE, 32'hA000, 32'h40, 6'd7, 32'h1,
			6'd8, 32'h2, 1, 1, 1, 32'hA040, 0);
		set_row(11, branch_pkg::BRC_LTU, 32'hB000, 32'hC, 6'd9, 32'h3,
			6'd10, 32'h4, 1, 0, 1, 32'hB00C, 0);

		// Random ordering rows, odd rows force opposite sign bits
		rng_state = 32'd82603;
		for (int k = NDIRECTED; k < NROWS; k++) begin
			case (k % 4)
				0: cls = branch_pkg::BRC_LT;
				1: cls = branch_pkg::BRC_GE;
				2: cls = branch_pkg::BRC_LTU;
				default: cls = branch_pkg::BRC_GEU;
			endcase
			rng_state = xorshift(rng_state);
			va = rng_state;
			rng_state = xorshift(rng_state);
			vb = rng_state;
			if (k % 2 == 1)
				va[31] = ~vb[31];
			rng_state = xorshift(rng_state);
			pc = rng_state & 32'hFFFF_FFFC;
			imm = {20'h0, rng_state[11:2], 2'b00};
			set_row(k, cls, pc, imm, 6'd11, va, 6'd12, vb, 0, 0,
				ordered_taken(cls, va, vb), pc + imm, 0);
		end
	endtask

	// ============================================================
	// Row sequencing
	// ============================================================

	task automatic apply_presets(input int r);
		if (rows[r].src_a != '0)
			write_reg(rows[r].src_a, rows[r].val_a);
		if (rows[r].src_b != '0) begin
			if (rows[r].late_b) begin
				alloc_reg(rows[r].src_b);
				late_rows.push_back(r);
			end else begin
				write_reg(rows[r].src_b, rows[r].val_b);
			end
		end
	endtask

	task automatic dispatch_row(input int r);
		int cnt;
		cnt = 0;
		while (!dispatch_ready_o && cnt < TIMEOUT) begin
			next_cycle();
			cnt++;
		end
		if (!dispatch_ready_o) begin
			report_timeout("dispatch_ready_o never rose", r);
			return;
		end
		dispatch_valid_i = 1'b1;
		dispatch_robid_i = branch_pkg::robid_t'(r);
		dispatch_class_i = rows[r].cls;
		dispatch_pc_i = rows[r].pc;
		dispatch_imm_i = rows[r].imm;
		dispatch_psrc_a_i = rows[r].src_a;
		dispatch_psrc_b_i = rows[r].src_b;
		dispatch_pdst_i = branch_pkg::preg_t'(r + 32);
		issued[r] = 1'b1;
		next_cycle();
		dispatch_valid_i = 1'b0;
	endtask

	// Waiting rows must still be unresolved before their operand is written
	task automatic release_late();
		int r;
		if (late_rows.size() == 0)
			return;
		foreach (pending[i]) begin
			if (rows[pending[i]].late_b)
				check_value("resolved before writeback", 32'(got_valid[pending[i]]), 0);
		end
		if (pending.size() >= `BR_NSTATION)
			check_value("dispatch_ready_o while busy", 32'(dispatch_ready_o), 0);
		while (late_rows.size() > 0) begin
			r = late_rows.pop_front();
			late_cycle[r] = cycle;
			write_reg(rows[r].src_b, rows[r].val_b);
		end
	endtask

	task automatic collect_results();
		int r;
		int cnt;
		int errs_before;
		while (pending.size() > 0) begin
			r = pending.pop_front();
			cur_row = r;
			errs_before = error_count;
			cnt = 0;
			while (!got_valid[r] && cnt < TIMEOUT && !timed_out) begin
				next_cycle();
				cnt++;
			end
			if (!got_valid[r]) begin
				report_timeout("no result came back", r);
			end else begin
				check_value("taken", 32'(got_taken[r]), 32'(rows[r].exp_taken));
				check_value("target", got_target[r], rows[r].exp_target);
				check_value("link", got_link[r], rows[r].exp_link);
				check_value("pdst", 32'(got_pdst[r]), 32'(r + 32));
				if (rows[r].late_b)
					check_value("resolved after writeback",
						32'(got_cycle[r] > late_cycle[r]), 1);
			end
			if (got_valid[r] && error_count == errs_before) begin
				rows_ok++;
				$display("row %0d rob %0d ok", r, r);
			end else begin
				rows_bad++;
				$display("row %0d rob %0d mismatch", r, r);
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		dispatch_valid_i = 1'b0;
		dispatch_robid_i = '0;
		dispatch_class_i = branch_pkg::BRC_EQ;
		dispatch_pc_i = '0;
		dispatch_imm_i = '0;
		dispatch_psrc_a_i = '0;
		dispatch_psrc_b_i = '0;
		dispatch_pdst_i = '0;
		wb_valid_i = 1'b0;
		wb_preg_i = '0;
		wb_data_i = '0;
		alloc_valid_i = 1'b0;
		alloc_preg_i = '0;
		build_table();
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int r = 0; r < NROWS && !timed_out; r++) begin
			cur_row = r;
			// The row after a held one was preset together with it
			if (r == 0 || !rows[r - 1].hold)
				apply_presets(r);
			// Presetting the next row first lets the two dispatch in consecutive cycles
			if (rows[r].hold && r + 1 < NROWS)
				apply_presets(r + 1);
			dispatch_row(r);
			pending.push_back(r);
			// A held row stays in its station while the next one dispatches
			if (!rows[r].hold) begin
				repeat (4) next_cycle();
				release_late();
				collect_results();
			end
		end

		$display("rows ok %0d, rows failed %0d, errors %0d, stray results %0d",
			rows_ok, rows_bad, error_count, stray_results);
		if (error_count == 0 && stray_results == 0 && !timed_out && rows_ok == NROWS)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
